// ==== calc_sym_pkg.sv ====
// symbol code definitions for the calculator input stream
// plus the ASCII bytes produced on the output side

package calc_sym_pkg;

	localparam int SYM_W = 7;  // symbol code width

	// symbol codes, digits 0..9 are codes 0x00..0x09
	localparam logic [SYM_W-1:0] SYM_ADD   = 7'h40;
	localparam logic [SYM_W-1:0] SYM_SUB   = 7'h41;
	localparam logic [SYM_W-1:0] SYM_MUL   = 7'h42;
	localparam logic [SYM_W-1:0] SYM_ENTER = 7'h30;
	localparam logic [SYM_W-1:0] SYM_SPACE = 7'h31;

	localparam logic [2:0] SYM_DIG_CLASS = 3'b000;    // upper bits of a digit
	localparam logic [4:0] SYM_OP_CLASS  = 5'b10000;  // upper bits of an operator

	// one symbol word seen as digit or as operator
	typedef union packed {
		struct packed {
			logic [2:0] cls;    // 000 marks a digit
			logic [3:0] value;  // binary digit value
		} dig;
		struct packed {
			logic [4:0] cls;    // 10000 marks an operator
			logic [1:0] op;     // same encoding as alu_op_e
		} opr;
	} sym_word_u;

	// output characters
	localparam logic [7:0] ASCII_ZERO  = 8'h30;
	localparam logic [7:0] ASCII_MINUS = 8'h2D;
	localparam logic [7:0] ASCII_NL    = 8'h0A;
	localparam logic [7:0] ASCII_E     = 8'h45;
	localparam logic [7:0] ASCII_R     = 8'h52;

endpackage

// ==== calc_op_pkg.sv ====
// arithmetic operation codes shared by the lexer and the ALU

package calc_op_pkg;

	// values equal the operator field of a symbol word
	typedef enum logic [1:0] {
		OP_ADD = 2'b00,
		OP_SUB = 2'b01,
		OP_MUL = 2'b10
	} alu_op_e;

endpackage

// ==== symbol_lexer.sv ====
`timescale 1ns/10ps
// symbol lexer
// checks operand, operator, operand, enter and builds one ALU job per line
// malformed lines are skipped up to enter and flagged with job_err

module symbol_lexer
	import calc_sym_pkg::*, calc_op_pkg::*;
#(
	parameter int DATA_W = 16
) (
	input  logic              CLK,
	input  logic              RST_N,
	input  logic              sym_valid,
	input  logic [SYM_W-1:0]  sym,
	output logic              sym_ready,
	output logic              job_valid,
	output logic [DATA_W-1:0] opnd_a,
	output logic [DATA_W-1:0] opnd_b,
	output alu_op_e           op,
	output logic              job_err,
	input  logic              job_ready
);

	localparam logic [2:0] LX_A    = 3'd0;  // first operand
	localparam logic [2:0] LX_OP   = 3'd1;  // waiting for operator after a space
	localparam logic [2:0] LX_B    = 3'd2;  // second operand
	localparam logic [2:0] LX_END  = 3'd3;  // waiting for enter after a space
	localparam logic [2:0] LX_SKIP = 3'd4;  // error, drop up to enter
	localparam logic [2:0] LX_JOB  = 3'd5;  // job offered to the ALU

	logic [2:0]        state;
	logic [2:0]        state_nxt;
	sym_word_u         sw;
	logic              take;
	logic              have_dig;  // current operand has at least one digit
	logic              bad;
	logic              is_digit;
	logic              is_oper;
	logic              is_enter;
	logic              is_space;
	logic [DATA_W-1:0] dig_ext;

	assign sw        = sym;
	assign take      = sym_valid & sym_ready;
	assign job_valid = (state == LX_JOB);
	assign is_digit  = (sw.dig.cls == SYM_DIG_CLASS) && (sw.dig.value <= 4'd9);
	assign is_oper   = (sw.opr.cls == SYM_OP_CLASS) && (sw.opr.op inside {OP_ADD, OP_SUB, OP_MUL});
	assign is_enter  = (sym == SYM_ENTER);
	assign is_space  = (sym == SYM_SPACE);
	assign dig_ext   = DATA_W'(sw.dig.value);

	always_comb begin
		state_nxt = state;
		bad = 1'b0;
		if (state == LX_JOB) begin
			if (job_ready)
				state_nxt = LX_A;
		end else if (take) begin
			case (state)
				LX_A: begin
					if (is_space && have_dig)
						state_nxt = LX_OP;
					else if (is_oper && have_dig)
						state_nxt = LX_B;
					else if (!is_digit && !is_space)
						bad = 1'b1;  // leading operator, enter or unknown code
				end
				LX_OP: begin
					if (is_oper)
						state_nxt = LX_B;
					else if (!is_space)
						bad = 1'b1;
				end
				LX_B: begin
					if (is_space && have_dig)
						state_nxt = LX_END;
					else if (is_enter && have_dig)
						state_nxt = LX_JOB;
					else if (!is_digit && !is_space)
						bad = 1'b1;  // repeated operator lands here too
				end
				LX_END: begin
					if (is_enter)
						state_nxt = LX_JOB;
					else if (!is_space)
						bad = 1'b1;
				end
				default: begin
					if (is_enter)
						state_nxt = LX_JOB;
				end
			endcase
			if (bad)
				state_nxt = is_enter ? LX_JOB : LX_SKIP;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state     <= LX_A;
			sym_ready <= 1'b0;
			have_dig  <= 1'b0;
			job_err   <= 1'b0;
		end else begin
			state     <= state_nxt;
			sym_ready <= (state_nxt != LX_JOB);  // blocked while a job waits
			if (job_valid && job_ready) begin
				have_dig <= 1'b0;
				job_err  <= 1'b0;
			end else if (take) begin
				if (bad)
					job_err <= 1'b1;
				if (is_digit)
					have_dig <= 1'b1;
				else if (is_oper)
					have_dig <= 1'b0;  // next operand starts empty
			end
		end
	end

	// operand accumulation, value*10 + digit
	always_ff @(posedge CLK) begin
		if (take && is_digit) begin
			if (state == LX_A)
				opnd_a <= have_dig ? (opnd_a << 3) + (opnd_a << 1) + dig_ext : dig_ext;
			else if (state == LX_B)
				opnd_b <= have_dig ? (opnd_b << 3) + (opnd_b << 1) + dig_ext : dig_ext;
		end
		if (take && is_oper && (state == LX_A || state == LX_OP))
			op <= alu_op_e'(sw.opr.op);
	end

endmodule

// ==== calc_alu.sv ====
`timescale 1ns/10ps
// calculator ALU
// add and subtract in one cycle, multiply by a DATA_W step shift-add loop
// the result is held until the formatter takes it

module calc_alu
	import calc_op_pkg::*;
#(
	parameter int DATA_W = 16
) (
	input  logic              CLK,
	input  logic              RST_N,
	input  logic              job_valid,
	input  logic [DATA_W-1:0] opnd_a,
	input  logic [DATA_W-1:0] opnd_b,
	input  alu_op_e           op,
	input  logic              job_err,
	output logic              job_ready,
	output logic              res_valid,
	output logic [DATA_W-1:0] res_mag,
	output logic              res_neg,
	output logic              res_err,
	input  logic              res_ready
);

	localparam int CNT_W = $clog2(DATA_W + 1);

	localparam logic [1:0] AL_IDLE = 2'd0;
	localparam logic [1:0] AL_MUL  = 2'd1;
	localparam logic [1:0] AL_DONE = 2'd2;

	logic [1:0]        state;
	logic [CNT_W-1:0]  cnt;     // multiply steps left
	logic [DATA_W-1:0] mcand;
	logic [DATA_W-1:0] mplier;
	logic              go;

	assign job_ready = (state == AL_IDLE);
	assign res_valid = (state == AL_DONE);
	assign go        = job_valid & job_ready;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= AL_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				AL_IDLE: begin
					if (go && !job_err && op == OP_MUL) begin
						state <= AL_MUL;
						cnt   <= CNT_W'(DATA_W);
					end else if (go) begin
						state <= AL_DONE;
					end
				end
				AL_MUL: begin
					if (cnt == '0)
						state <= AL_DONE;  // one extra cycle after the last step
					else
						cnt <= cnt - 1'b1;
				end
				default: begin
					if (res_ready)
						state <= AL_IDLE;
				end
			endcase
		end
	end

	// res_mag doubles as the product accumulator
	always_ff @(posedge CLK) begin
		if (go) begin
			res_err <= job_err;
			res_neg <= 1'b0;
			mcand   <= opnd_a;
			mplier  <= opnd_b;
			if (job_err) begin
				res_mag <= '0;
			end else begin
				case (op)
					OP_SUB: begin
						if (opnd_b > opnd_a) begin
							res_mag <= opnd_b - opnd_a;
							res_neg <= 1'b1;
						end else begin
							res_mag <= opnd_a - opnd_b;
						end
					end
					OP_MUL:  res_mag <= '0;
					default: res_mag <= opnd_a + opnd_b;  // wraps mod 2**DATA_W
				endcase
			end
		end else if (state == AL_MUL && cnt != '0) begin
			if (mplier[0])
				res_mag <= res_mag + mcand;
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

endmodule

// ==== result_formatter.sv ====
`timescale 1ns/10ps
// result formatter
// splits the magnitude into decimal digits, one digit per cycle,
// then streams sign, digits and newline as ASCII, or ERR for a bad line

module result_formatter
	import calc_sym_pkg::*;
#(
	parameter int DATA_W     = 16,
	parameter int MAX_DIGITS = 5
) (
	input  logic              CLK,
	input  logic              RST_N,
	input  logic              res_valid,
	input  logic [DATA_W-1:0] res_mag,
	input  logic              res_neg,
	input  logic              res_err,
	output logic              res_ready,
	output logic              char_valid,
	output logic [7:0]        char,
	input  logic              char_ready
);

	localparam int PTR_W = $clog2(MAX_DIGITS);

	localparam logic [2:0] FM_IDLE  = 3'd0;
	localparam logic [2:0] FM_DIV   = 3'd1;
	localparam logic [2:0] FM_MINUS = 3'd2;
	localparam logic [2:0] FM_DIGIT = 3'd3;
	localparam logic [2:0] FM_NL    = 3'd4;
	localparam logic [2:0] FM_E     = 3'd5;
	localparam logic [2:0] FM_R1    = 3'd6;
	localparam logic [2:0] FM_R2    = 3'd7;

	logic [2:0]        state;
	logic [PTR_W-1:0]  dptr;                  // write index, then read index
	logic [3:0]        digits [MAX_DIGITS];   // least significant first
	logic [DATA_W-1:0] quot;
	logic [DATA_W-1:0] quot_div10;
	logic              neg;
	logic              take;

	assign res_ready  = (state == FM_IDLE);
	assign char_valid = (state >= FM_MINUS);  // all byte states sit above DIV
	assign take       = char_valid & char_ready;
	assign quot_div10 = quot / DATA_W'(10);

	always_comb begin
		case (state)
			FM_MINUS:     char = ASCII_MINUS;
			FM_DIGIT:     char = ASCII_ZERO + 8'(digits[dptr]);
			FM_E:         char = ASCII_E;
			FM_R1, FM_R2: char = ASCII_R;
			default:      char = ASCII_NL;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= FM_IDLE;
			dptr  <= '0;
		end else begin
			case (state)
				FM_IDLE: begin
					dptr <= '0;
					if (res_valid)
						state <= res_err ? FM_E : FM_DIV;
				end
				FM_DIV: begin
					// stop on a zero quotient, dptr then points at the top digit
					if (quot_div10 == '0)
						state <= neg ? FM_MINUS : FM_DIGIT;
					else
						dptr <= dptr + 1'b1;
				end
				FM_MINUS: begin
					if (take)
						state <= FM_DIGIT;
				end
				FM_DIGIT: begin
					if (take && dptr == '0)
						state <= FM_NL;
					else if (take)
						dptr <= dptr - 1'b1;
				end
				FM_NL: begin
					if (take)
						state <= FM_IDLE;
				end
				FM_E: begin
					if (take)
						state <= FM_R1;
				end
				FM_R1: begin
					if (take)
						state <= FM_R2;
				end
				default: begin
					if (take)
						state <= FM_NL;
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == FM_IDLE && res_valid) begin
			quot <= res_mag;
			neg  <= res_neg;
		end else if (state == FM_DIV) begin
			digits[dptr] <= 4'(quot % DATA_W'(10));
			quot         <= quot_div10;
		end
	end

endmodule

// ==== calc_top.sv ====
`timescale 1ns/10ps
// calculator top level
// symbol lexer, ALU and decimal formatter chained by valid/ready channels

module calc_top
	import calc_sym_pkg::*, calc_op_pkg::*;
#(
	parameter int DATA_W = 16
) (
	input  logic             CLK,
	input  logic             RST_N,
	input  logic             sym_valid,
	output logic             sym_ready,
	input  logic [SYM_W-1:0] sym,
	output logic             char_valid,
	input  logic             char_ready,
	output logic [7:0]       char
);

	// digits of 2**DATA_W-1, 77/256 is just under log10(2)
	localparam int MAX_DIGITS = (DATA_W * 77) / 256 + 1;

	logic              job_valid;
	logic              job_ready;
	logic [DATA_W-1:0] opnd_a;
	logic [DATA_W-1:0] opnd_b;
	alu_op_e           op;
	logic              job_err;
	logic              res_valid;
	logic              res_ready;
	logic [DATA_W-1:0] res_mag;
	logic              res_neg;
	logic              res_err;

	symbol_lexer #(
		.DATA_W (DATA_W)
	) symbol_lexer_i (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.sym_valid (sym_valid),
		.sym       (sym),
		.sym_ready (sym_ready),
		.job_valid (job_valid),
		.opnd_a    (opnd_a),
		.opnd_b    (opnd_b),
		.op        (op),
		.job_err   (job_err),
		.job_ready (job_ready)
	);

	calc_alu #(
		.DATA_W (DATA_W)
	) calc_alu_i (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.job_valid (job_valid),
		.opnd_a    (opnd_a),
		.opnd_b    (opnd_b),
		.op        (op),
		.job_err   (job_err),
		.job_ready (job_ready),
		.res_valid (res_valid),
		.res_mag   (res_mag),
		.res_neg   (res_neg),
		.res_err   (res_err),
		.res_ready (res_ready)
	);

	result_formatter #(
		.DATA_W     (DATA_W),
		.MAX_DIGITS (MAX_DIGITS)
	) result_formatter_i (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.res_valid  (res_valid),
		.res_mag    (res_mag),
		.res_neg    (res_neg),
		.res_err    (res_err),
		.res_ready  (res_ready),
		.char_valid (char_valid),
		.char       (char),
		.char_ready (char_ready)
	);

endmodule

// ==== calc_tb_sva.sv ====
`timescale 1ns/10ps
// handshake and reset assertions for the calculator top level

module calc_tb_sva (
	input logic       CLK,
	input logic       RST_N,
	input logic       sym_ready,
	input logic       char_valid,
	input logic       char_ready,
	input logic [7:0] char
);

	int assert_fail_cnt = 0;  // read by the testbench

	reset_quiet: assert property (@(posedge CLK) !RST_N |-> !char_valid && !sym_ready)
		else begin
			assert_fail_cnt++;
			$error("char_valid or sym_ready high during reset");
		end

	// byte must wait for char_ready
	char_hold: assert property (@(posedge CLK) disable iff (!RST_N)
			char_valid && !char_ready |=> char_valid && $stable(char))
		else begin
			assert_fail_cnt++;
			$error("char dropped or changed before char_ready");
		end

	char_known: assert property (@(posedge CLK) disable iff (!RST_N)
			char_valid |-> !$isunknown(char))
		else begin
			assert_fail_cnt++;
			$error("char unknown while char_valid is high");
		end

endmodule

bind calc_top calc_tb_sva calc_tb_sva_i (
	.CLK        (CLK),
	.RST_N      (RST_N),
	.sym_ready  (sym_ready),
	.char_valid (char_valid),
	.char_ready (char_ready),
	.char       (char)
);

// ==== calc_tb.sv ====
`timescale 1ns/10ps
// calculator testbench
// feeds expression rows through calc_top and checks every returned byte,
// once with char_ready held high and once with random back-pressure

module calc_tb
	import calc_sym_pkg::*;
();

	localparam int  DATA_W     = 16;
	localparam time DRIVE_DLY  = 10ns;
	localparam int  TMO_CYCLES = 200;  // per wait

	logic             CLK;
	logic             RST_N;
	logic             sym_valid;
	logic             sym_ready;
	logic [SYM_W-1:0] sym;
	logic             char_valid;
	logic             char_ready;
	logic [7:0]       char;

	string       stim_q [$];  // expression text without the enter
	string       exp_q [$];   // expected output bytes
	int          mismatch_cnt;
	int          timeout_cnt;
	logic [15:0] lfsr_state;

	calc_top #(
		.DATA_W (DATA_W)
	) calc_top_i (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.sym_valid  (sym_valid),
		.sym_ready  (sym_ready),
		.sym        (sym),
		.char_valid (char_valid),
		.char_ready (char_ready),
		.char       (char)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// fibonacci LFSR with taps 16 14 13 11
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	// text character to symbol code
	function automatic logic [SYM_W-1:0] sym_code(input byte c);
		if (c >= "0" && c <= "9")
			return SYM_W'(c - "0");
		case (c)
			"+":     return SYM_ADD;
			"-":     return SYM_SUB;
			"*":     return SYM_MUL;
			" ":     return SYM_SPACE;
			default: return 7'h7F;  // unknown code
		endcase
	endfunction

	task automatic add_row(input string s, input string e);
		stim_q.push_back(s);
		exp_q.push_back(e);
	endtask

	task automatic next_cycle();
		@(posedge CLK);
		#DRIVE_DLY;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic send_symbol(input logic [SYM_W-1:0] code);
		int t;
		t = 0;
		sym       = code;
		sym_valid = 1'b1;
		while (!sym_ready && t < TMO_CYCLES) begin
			next_cycle();
			t++;
		end
		if (!sym_ready) begin
			timeout_cnt++;
			$display("Timeout: sym_ready stayed low for symbol 0x%0h", code);
		end
		next_cycle();  // transfer edge
		sym_valid = 1'b0;
	endtask

	task automatic receive_line(input int row, input string e, input bit use_bp);
		int   t;
		bit   got;
		logic [7:0] c;
		for (int i = 0; i < e.len(); i++) begin
			t   = 0;
			got = 1'b0;
			c   = '0;
			while (!got && t < TMO_CYCLES) begin
				char_ready = use_bp ? lfsr_bit() : 1'b1;
				if (char_valid && char_ready) begin
					got = 1'b1;
					c   = char;
				end
				next_cycle();
				t++;
			end
			if (!got) begin
				timeout_cnt++;
				$display("Timeout: no output byte %0d for row %0d", i, row);
				char_ready = 1'b0;
				return;
			end
			check_value($sformatf("char (row %0d, byte %0d)", row, i), c, e[i]);
		end
		char_ready = 1'b0;
	endtask

	task automatic run_row(input int row, input bit use_bp);
		string s;
		s = stim_q[row];
		for (int i = 0; i < s.len(); i++)
			send_symbol(sym_code(s[i]));
		send_symbol(SYM_ENTER);
		receive_line(row, exp_q[row], use_bp);
	endtask

	initial begin
		RST_N        = 1'b1;
		sym_valid    = 1'b0;
		sym          = '0;
		char_ready   = 1'b0;
		mismatch_cnt = 0;
		timeout_cnt  = 0;
		lfsr_state   = 16'd31070;

		add_row("12 + 30", "42\n");
		add_row("7-20", "-13\n");
		add_row("20-20", "0\n");
		add_row("250*3", "750\n");
		add_row("300*300", "24464\n");  // 90000 wraps
		add_row("+5", "ERR\n");
		add_row("5++3", "ERR\n");
		add_row("9 * 9", "81\n");
		add_row("65535+1", "0\n");
		add_row("4?2", "ERR\n");
		add_row("100 - 1 ", "99\n");

		#DRIVE_DLY;
		RST_N = 1'b0;
		repeat (3) @(posedge CLK);
		#DRIVE_DLY;
		RST_N = 1'b1;
		next_cycle();
		check_value("sym_ready", sym_ready, 1'b1);  // up on the first cycle after reset

		// second pass repeats all rows under back-pressure
		for (int pass = 0; pass < 2; pass++) begin
			for (int r = 0; r < stim_q.size(); r++)
				run_row(r, pass == 1);
		end

		repeat (2) next_cycle();
		check_value("char_valid", char_valid, 1'b0);  // no byte beyond the last newline
		$display("mismatches: %0d, timeouts: %0d, assertion failures: %0d",
			mismatch_cnt, timeout_cnt, calc_top_i.calc_tb_sva_i.assert_fail_cnt);
		if (mismatch_cnt == 0 && timeout_cnt == 0 &&
				calc_top_i.calc_tb_sva_i.assert_fail_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
calc_sym_pkg.sv
calc_op_pkg.sv
symbol_lexer.sv
calc_alu.sv
result_formatter.sv
calc_top.sv
calc_tb_sva.sv
calc_tb.sv
